/* logic/img_pkg.sv */
`default_nettype none

package img_pkg;

    // frame geometry.
    localparam int IMG_W = 16;
    localparam int IMG_H = 8;

    // gray level width.
    localparam int GRAY_W = 8;

    // gray pixel beat from the source.
    typedef struct packed {
        logic              valid;
        logic              sop;
        logic              eop;
        logic [GRAY_W-1:0] data;
    } gray_beat_t;

    // one bit per pixel after thresholding, also used for edge results.
    typedef struct packed {
        logic valid;
        logic sop;
        logic eop;
        logic data;
    } bin_beat_t;

endpackage

`default_nettype wire

/* logic/sobel_pkg.sv */
`default_nettype none

package sobel_pkg;

    // wide enough for the weighted sums and their differences.
    localparam int GRAD_W = 8;

    // vertical three-pixel column, top is the oldest row.
    typedef struct packed {
        logic top;
        logic mid;
        logic bot;
    } sobel_col_t;

    // sobel input beat to output beat, in clock cycles.
    localparam int SOBEL_LAT = 4;

endpackage

`default_nettype wire

/* logic/binarizer.sv */
`timescale 1ns/10ps
`default_nettype none

module binarizer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [img_pkg::GRAY_W-1:0] threshold,
    input  img_pkg::gray_beat_t        gray,
    output img_pkg::bin_beat_t         bin
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bin <= '0;
        end else begin
            bin.valid <= gray.valid;
            bin.sop   <= gray.sop;
            bin.eop   <= gray.eop;
            // ties count as foreground.
            bin.data  <= (gray.data >= threshold);
        end
    end

    // frame markers only ride on real beats.
    assert property (@(posedge clk) disable iff (!rst_n)
        (gray.sop || gray.eop) |-> gray.valid)
        else $error("binarizer: sop/eop on an idle beat");

endmodule

`default_nettype wire

/* logic/line_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module line_buffer #(
    parameter int LINE_LEN = img_pkg::IMG_W
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  img_pkg::bin_beat_t    pix,
    output sobel_pkg::sobel_col_t column
);

    // one row of history each, index 0 is the newest bit.
    logic [LINE_LEN-1:0] line_mid;
    logic [LINE_LEN-1:0] line_top;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_mid <= '0;
            line_top <= '0;
            column   <= '0;
        end else if (pix.valid) begin
            line_mid[0] <= pix.data;
            line_top[0] <= line_mid[LINE_LEN-1];
            for (int i = 1; i < LINE_LEN; i++) begin
                line_mid[i] <= line_mid[i-1];
                line_top[i] <= line_top[i-1];
            end
            // the bits leaving each row are LINE_LEN and 2*LINE_LEN beats old.
            column.bot <= pix.data;
            column.mid <= line_mid[LINE_LEN-1];
            column.top <= line_top[LINE_LEN-1];
        end
    end

endmodule

`default_nettype wire

/* logic/sobel.sv */
`timescale 1ns/10ps
`default_nettype none

module sobel (
    input  logic                  clk,
    input  logic                  rst_n,
    input  img_pkg::bin_beat_t    pix,
    input  sobel_pkg::sobel_col_t column,
    output img_pkg::bin_beat_t    edge_beat
);

    import sobel_pkg::*;

    typedef struct packed {
        logic valid;
        logic sop;
        logic eop;
    } ctl_t;

    // stage controls, index 0 is the youngest.
    ctl_t [SOBEL_LAT-1:0] ctl;

    // previous two columns, win_b is the older one.
    sobel_col_t win_a;
    sobel_col_t win_b;

    logic [GRAD_W-1:0] l_old;
    logic [GRAD_W-1:0] l_new;
    logic [GRAD_W-1:0] t_sum;
    logic [GRAD_W-1:0] b_sum;
    logic [GRAD_W-1:0] gx;
    logic [GRAD_W-1:0] gy;
    logic [GRAD_W-1:0] mag;

    // 1-2-1 weighted sum of three samples.
    function automatic logic [GRAD_W-1:0] wsum(input logic a, input logic b, input logic c);
        return GRAD_W'(a) + GRAD_W'({b, 1'b0}) + GRAD_W'(c);
    endfunction

    function automatic logic [GRAD_W-1:0] absdiff(input logic [GRAD_W-1:0] a,
                                                  input logic [GRAD_W-1:0] b);
        return (a > b) ? (a - b) : (b - a);
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctl <= '0;
        end else begin
            ctl <= {ctl[SOBEL_LAT-2:0], pix.valid, pix.sop, pix.eop};
        end
    end

    // stage one, moves with the line buffer so column is the newest pixel.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_a <= '0;
            win_b <= '0;
        end else if (pix.valid) begin
            win_a <= column;
            win_b <= win_a;
        end
    end

    // stages two to four.
    always_ff @(posedge clk) begin
        if (ctl[0].valid) begin
            l_old <= wsum(win_b.top, win_b.mid, win_b.bot);
            l_new <= wsum(column.top, column.mid, column.bot);
            t_sum <= wsum(win_b.top, win_a.top, column.top);
            b_sum <= wsum(win_b.bot, win_a.bot, column.bot);
        end
        if (ctl[1].valid) begin
            gx <= absdiff(l_old, l_new);
            gy <= absdiff(t_sum, b_sum);
        end
        if (ctl[2].valid) begin
            mag <= gx + gy;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            edge_beat <= '0;
        end else begin
            edge_beat.valid <= ctl[SOBEL_LAT-1].valid;
            edge_beat.sop   <= ctl[SOBEL_LAT-1].sop;
            edge_beat.eop   <= ctl[SOBEL_LAT-1].eop;
            if (ctl[SOBEL_LAT-1].valid) begin
                edge_beat.data <= |mag;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        edge_beat.sop |-> edge_beat.valid)
        else $error("sobel: output sop without valid");

    assert property (@(posedge clk) disable iff (!rst_n)
        edge_beat.eop |-> edge_beat.valid)
        else $error("sobel: output eop without valid");

    // accepted at edge c, shown after edge c+SOBEL_LAT, so seen one sample later.
    assert property (@(posedge clk) disable iff (!rst_n)
        pix.valid |-> ##(SOBEL_LAT + 1) edge_beat.valid)
        else $error("sobel: output beat missing");

    assert property (@(posedge clk) disable iff (!rst_n)
        edge_beat.valid |-> $past(pix.valid, SOBEL_LAT + 1))
        else $error("sobel: output beat without input");

endmodule

`default_nettype wire

/* logic/edge_detect_top.sv */
`timescale 1ns/10ps
`default_nettype none

module edge_detect_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [img_pkg::GRAY_W-1:0] threshold,
    input  img_pkg::gray_beat_t        in,
    output img_pkg::bin_beat_t         out
);

    import img_pkg::*;
    import sobel_pkg::*;

    bin_beat_t  bin_beat;
    sobel_col_t column;

    binarizer u_binarizer (
        .clk       (clk),
        .rst_n     (rst_n),
        .threshold (threshold),
        .gray      (in),
        .bin       (bin_beat)
    );

    line_buffer u_line_buffer (
        .clk    (clk),
        .rst_n  (rst_n),
        .pix    (bin_beat),
        .column (column)
    );

    sobel u_sobel (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix       (bin_beat),
        .column    (column),
        .edge_beat (out)
    );

endmodule

`default_nettype wire

/* test/tb_edge_detect.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_edge_detect;

    import img_pkg::*;
    import sobel_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int FRAME_BEATS = IMG_W * IMG_H;
    localparam int TOP_LAT = SOBEL_LAT + 1;
    localparam int NUM_FRAMES = 4;
    localparam int MAX_GAP = 3;
    // every frame counted as worst case gapped, then three times that.
    localparam int STIM_CYCLES = NUM_FRAMES * FRAME_BEATS * (MAX_GAP + 1);
    localparam int TIMEOUT_CYCLES = 3 * STIM_CYCLES;

    typedef struct packed {
        logic        sop;
        logic        eop;
        logic        data;
        logic [31:0] accept_cycle;
    } exp_beat_t;

    logic              clk = 1'b0;
    logic              rst_n;
    logic [GRAY_W-1:0] threshold;
    gray_beat_t        in_beat;
    bin_beat_t         out_beat;

    exp_beat_t exp_q[$];
    logic      hist[$];
    integer    seed = 32'h60da79b8;
    int        cycle_cnt = 0;
    int        out_total = 0;
    int        frame_outs = 0;

    edge_detect_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .threshold (threshold),
        .in        (in_beat),
        .out       (out_beat)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout: run stopped after %0d cycles", cycle_cnt));
        end
    end

    // binarized history since reset, negative indices read as 0.
    function automatic int sample(input int k);
        if (k < 0) begin
            return 0;
        end
        return int'(hist[k]);
    endfunction

    function automatic logic model_edge(input int n);
        int l_old;
        int l_new;
        int t_sum;
        int b_sum;
        int gx;
        int gy;
        l_old = sample(n - 2 - 2 * IMG_W) + 2 * sample(n - 2 - IMG_W) + sample(n - 2);
        l_new = sample(n - 2 * IMG_W) + 2 * sample(n - IMG_W) + sample(n);
        t_sum = sample(n - 2 - 2 * IMG_W) + 2 * sample(n - 1 - 2 * IMG_W)
              + sample(n - 2 * IMG_W);
        b_sum = sample(n - 2) + 2 * sample(n - 1) + sample(n);
        gx = (l_old > l_new) ? (l_old - l_new) : (l_new - l_old);
        gy = (t_sum > b_sum) ? (t_sum - b_sum) : (b_sum - t_sum);
        return (gx + gy) != 0;
    endfunction

    // square on a slowly rising background.
    function automatic logic [GRAY_W-1:0] gray_at(input int x, input int y);
        if (x >= 4 && x < 12 && y >= 2 && y < 6) begin
            return 8'hc8;
        end
        return GRAY_W'(16 + 4 * x + 2 * y);
    endfunction

    task automatic check_output();
        exp_beat_t e;
        assert (exp_q.size() != 0)
            else fail_run("output beat arrived with no input beat pending");
        e = exp_q.pop_front();
        assert (out_beat.data == e.data)
            else fail_run($sformatf("Error: out.data expected 0x%0h got 0x%0h at beat %0d",
                                    e.data, out_beat.data, out_total));
        assert (out_beat.sop == e.sop)
            else fail_run($sformatf("Error: out.sop expected 0x%0h got 0x%0h at beat %0d",
                                    e.sop, out_beat.sop, out_total));
        assert (out_beat.eop == e.eop)
            else fail_run($sformatf("Error: out.eop expected 0x%0h got 0x%0h at beat %0d",
                                    e.eop, out_beat.eop, out_total));
        assert (cycle_cnt == e.accept_cycle + TOP_LAT)
            else fail_run($sformatf("Error: out latency expected 0x%0h got 0x%0h at beat %0d",
                                    TOP_LAT, cycle_cnt - e.accept_cycle, out_total));
        out_total = out_total + 1;
        frame_outs = frame_outs + 1;
    endtask

    // outputs settle after the rising edge.
    always @(negedge clk) begin
        if (rst_n && out_beat.valid) begin
            check_output();
        end else if (rst_n) begin
            assert (!out_beat.sop && !out_beat.eop)
                else fail_run("output sop or eop raised on an idle cycle");
        end
    end

    task automatic send_beat(input logic [GRAY_W-1:0] gray, input logic sop, input logic eop);
        exp_beat_t e;
        int n;
        @(negedge clk);
        in_beat.valid = 1'b1;
        in_beat.sop = sop;
        in_beat.eop = eop;
        in_beat.data = gray;
        hist.push_back(gray >= threshold);
        n = hist.size() - 1;
        e.sop = sop;
        e.eop = eop;
        e.data = model_edge(n);
        e.accept_cycle = cycle_cnt + 1;
        exp_q.push_back(e);
    endtask

    task automatic idle_beat();
        @(negedge clk);
        in_beat = '0;
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        // the last beat is due TOP_LAT cycles after it went in.
        while (exp_q.size() != 0 && waited < TOP_LAT + 2) begin
            @(negedge clk);
            waited = waited + 1;
        end
        // room for any stray beat to show up.
        repeat (TOP_LAT + 2) @(negedge clk);
    endtask

    task automatic send_frame(input logic [GRAY_W-1:0] thr, input int max_gap);
        int gap;
        idle_beat();
        threshold = thr;
        frame_outs = 0;
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                send_beat(gray_at(x, y), x == 0 && y == 0, x == IMG_W - 1 && y == IMG_H - 1);
                if (max_gap > 0) begin
                    gap = $unsigned($random(seed)) % (max_gap + 1);
                    repeat (gap) idle_beat();
                end
            end
        end
        idle_beat();
        wait_for_drain();
        assert (frame_outs == FRAME_BEATS)
            else fail_run($sformatf("Error: output beat count expected 0x%0h got 0x%0h",
                                    FRAME_BEATS, frame_outs));
    endtask

    task automatic test_reset_state();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (!out_beat.valid && !out_beat.sop && !out_beat.eop)
                else fail_run($sformatf("Error: out valid/sop/eop in reset expected 0x0 got 0x%0h",
                                        {out_beat.valid, out_beat.sop, out_beat.eop}));
        end
        rst_n = 1'b1;
        repeat (8) begin
            @(negedge clk);
            assert (!out_beat.valid && !out_beat.sop && !out_beat.eop)
                else fail_run($sformatf("Error: out valid/sop/eop idle expected 0x0 got 0x%0h",
                                        {out_beat.valid, out_beat.sop, out_beat.eop}));
        end
    endtask

    // latency is checked on every output beat.
    task automatic test_continuous_frame();
        send_frame(8'h80, 0);
    endtask

    task automatic test_gapped_frame();
        send_frame(8'h40, MAX_GAP);
    endtask

    // both thresholds give a uniform binary frame.
    task automatic test_threshold();
        send_frame(8'h00, 0);
        send_frame(8'hd0, 0);
    endtask

    initial begin
        rst_n = 1'b0;
        in_beat = '0;
        threshold = '0;
        test_reset_state();
        test_continuous_frame();
        test_gapped_frame();
        test_threshold();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* edge_detect.f */
logic/img_pkg.sv
logic/sobel_pkg.sv
logic/binarizer.sv
logic/line_buffer.sv
logic/sobel.sv
logic/edge_detect_top.sv
test/tb_edge_detect.sv

/* Makefile */
TOP := tb_edge_detect
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "all tests passed" $(LOG)

obj_dir/V$(TOP): edge_detect.f $(wildcard logic/*.sv test/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f edge_detect.f

lint:
	verilator --lint-only -Wall --assert --top-module edge_detect_top \
		logic/img_pkg.sv logic/sobel_pkg.sv logic/binarizer.sv \
		logic/line_buffer.sv logic/sobel.sv logic/edge_detect_top.sv

clean:
	rm -rf obj_dir $(LOG)
